// File: bench/sdram_model.sv
`include "mem_map_consts.svh"

module sdram_model (
    input  logic                         CLOCK_50,
    input  sdram_port_pkg::sdram_cmd_t   sdram_cmd,
    output logic [`MEM_SDRAM_DATA_W-1:0] sdram_rddata,
    output logic                         sdram_req_wait,
    // from the bench to restart the beat count per access
    input  logic                         beat_clear,
    input  logic [`MEM_SDRAM_ADDR_W-1:0] exp_base,
    input  logic [1:0]                   exp_lanes,
    output int                           beat_cnt,
    output logic                         rule_err
);

    // 4096 half-words cover the test window
    logic [`MEM_SDRAM_DATA_W-1:0] mem [0:4095];
    // extra wait cycles left before the beat on the port is taken
    logic [1:0]                   wait_cnt;
    logic                         active;

    assign active         = sdram_cmd.read_en | sdram_cmd.write_en;
    assign sdram_req_wait = wait_cnt != 2'd0;
    // read data valid in the accepting cycle
    assign sdram_rddata   = mem[sdram_cmd.addr[11:0]];

    initial begin
        wait_cnt = 2'd0;
        beat_cnt = 0;
        rule_err = 1'b0;
    end

    always @(posedge CLOCK_50) begin
        if (beat_clear) begin
            beat_cnt <= 0;
        end else if (active && wait_cnt != 2'd0) begin
            wait_cnt <= wait_cnt - 2'd1;
        end else if (active) begin
            // beat accepted at ascending half-word addresses
            assert (sdram_cmd.addr == exp_base + `MEM_SDRAM_ADDR_W'(beat_cnt))
            else begin
                $display("[FAIL] t=%0t sdram_cmd.addr expected %h got %h", $time,
                         exp_base + `MEM_SDRAM_ADDR_W'(beat_cnt), sdram_cmd.addr);
                rule_err <= 1'b1;
            end
            assert (sdram_cmd.byte_en == exp_lanes)
            else begin
                $display("[FAIL] t=%0t sdram_cmd.byte_en expected %b got %b", $time,
                         exp_lanes, sdram_cmd.byte_en);
                rule_err <= 1'b1;
            end
            if (sdram_cmd.write_en && sdram_cmd.byte_en[0]) begin
                mem[sdram_cmd.addr[11:0]][7:0] <= sdram_cmd.wrdata[7:0];
            end
            if (sdram_cmd.write_en && sdram_cmd.byte_en[1]) begin
                mem[sdram_cmd.addr[11:0]][15:8] <= sdram_cmd.wrdata[15:8];
            end
            beat_cnt <= beat_cnt + 1;
            // 0 to 3 extra cycles for the next beat
            wait_cnt <= 2'($urandom % 4);
        end
    end

endmodule

// File: bench/tb_mem_subsystem.sv
`include "mem_map_consts.svh"

module tb_mem_subsystem;

    localparam int clk_period   = 8;
    localparam int reset_cycles = 5;
    // upper bound on accesses issued by all tests
    localparam int max_accesses = 80;
    // sdram doubleword with three waits on each of four beats plus handshake
    localparam int worst_cycles = 24;

    logic                         CLOCK_50;
    logic                         KEY0;
    mem_bus_pkg::bus_req_t        bus_req;
    logic                         read_enable;
    logic                         write_enable;
    logic [`MEM_DATA_W-1:0]       read_data;
    logic                         read_done;
    logic                         write_done;
    sdram_port_pkg::sdram_cmd_t   sdram_cmd;
    logic [`MEM_SDRAM_DATA_W-1:0] sdram_rddata;
    logic                         sdram_req_wait;
    logic                         beat_clear;
    logic [`MEM_SDRAM_ADDR_W-1:0] exp_base;
    logic [1:0]                   exp_lanes;
    int                           beat_cnt;
    logic                         rule_err;

    // reference images with one byte per entry
    logic [7:0] ram_ref [0:`MEM_RAM_BYTES-1];
    // matches the model depth
    logic [7:0] sdram_ref [0:8191];

    mem_subsystem u_mem_subsystem (
        .CLOCK_50       (CLOCK_50),
        .KEY0           (KEY0),
        .bus_req        (bus_req),
        .read_enable    (read_enable),
        .write_enable   (write_enable),
        .read_data      (read_data),
        .read_done      (read_done),
        .write_done     (write_done),
        .sdram_cmd      (sdram_cmd),
        .sdram_rddata   (sdram_rddata),
        .sdram_req_wait (sdram_req_wait)
    );

    sdram_model u_sdram_model (
        .CLOCK_50       (CLOCK_50),
        .sdram_cmd      (sdram_cmd),
        .sdram_rddata   (sdram_rddata),
        .sdram_req_wait (sdram_req_wait),
        .beat_clear     (beat_clear),
        .exp_base       (exp_base),
        .exp_lanes      (exp_lanes),
        .beat_cnt       (beat_cnt),
        .rule_err       (rule_err)
    );

    initial begin
        CLOCK_50 = 1'b0;
        forever #(clk_period / 2) CLOCK_50 = ~CLOCK_50;
    end

    initial begin
        #(clk_period * (reset_cycles + max_accesses * worst_cycles));
        $display("watchdog expired before all tests finished");
        $display("TESTS FAILED");
        $fatal(1);
    end

    task automatic report_mismatch(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("[FAIL] t=%0t %s expected %h got %h", $time, name, expected, actual);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic report_problem(input string what);
        $display("[FAIL] t=%0t %s", $time, what);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    function automatic mem_bus_pkg::region_e region_of(input logic [63:0] a);
        if (a >= `MEM_RAM_BASE && a < `MEM_RAM_BASE + `MEM_RAM_BYTES) begin
            return mem_bus_pkg::region_ram;
        end else if (a >= `MEM_SDRAM_MIN && a < `MEM_SDRAM_MAX) begin
            return mem_bus_pkg::region_sdram;
        end
        return mem_bus_pkg::region_none;
    endfunction

    function automatic int access_bytes(input mem_bus_pkg::ls_type_e t);
        case (t)
            mem_bus_pkg::ls_b, mem_bus_pkg::ls_bu: return 1;
            mem_bus_pkg::ls_h, mem_bus_pkg::ls_hu: return 2;
            mem_bus_pkg::ls_w, mem_bus_pkg::ls_wu: return 4;
            default: return 8;
        endcase
    endfunction

    // unmapped bytes read as zero
    function automatic logic [7:0] ref_byte(input logic [63:0] a);
        case (region_of(a))
            mem_bus_pkg::region_ram:   return ram_ref[12'(a - `MEM_RAM_BASE)];
            mem_bus_pkg::region_sdram: return sdram_ref[a[12:0]];
            default:                   return 8'h00;
        endcase
    endfunction

    // little endian bytes then sign or zero fill above them
    function automatic logic [63:0] expected_load(input logic [63:0] a,
                                                  input mem_bus_pkg::ls_type_e t);
        logic [63:0] raw;
        int          nb;
        nb  = access_bytes(t);
        raw = '0;
        for (int i = 0; i < nb; i++) begin
            raw[i*8 +: 8] = ref_byte(a + 64'(i));
        end
        if (t inside {mem_bus_pkg::ls_b, mem_bus_pkg::ls_h, mem_bus_pkg::ls_w} &&
            raw[nb*8-1]) begin
            raw = raw | (~64'd0 << (nb * 8));
        end
        return raw;
    endfunction

    function automatic logic [63:0] random_dword();
        return {$urandom, $urandom};
    endfunction

    // one enable pulse then wait for the matching done
    task automatic run_access(input logic [63:0] a, input logic [63:0] wdata,
                              input mem_bus_pkg::ls_type_e t, input logic wr,
                              output logic [63:0] rdata, output int edges);
        mem_bus_pkg::bus_req_t r;
        int                    n;
        r.addr     = a;
        r.wdata    = wdata;
        r.ls_type  = t;
        r.is_write = wr;
        n          = 0;
        @(posedge CLOCK_50);
        bus_req      <= r;
        read_enable  <= !wr;
        write_enable <= wr;
        beat_clear   <= 1'b1;
        exp_base     <= a[`MEM_SDRAM_ADDR_W:1];
        // byte accesses use the lane of address bit 0
        if (t == mem_bus_pkg::ls_b || t == mem_bus_pkg::ls_bu) begin
            exp_lanes <= a[0] ? 2'b10 : 2'b01;
        end else begin
            exp_lanes <= 2'b11;
        end
        // enable edge
        @(posedge CLOCK_50);
        read_enable  <= 1'b0;
        write_enable <= 1'b0;
        beat_clear   <= 1'b0;
        @(negedge CLOCK_50);
        assert ((wr ? write_done : read_done) == 1'b0)
        else report_problem("done did not fall on the enable edge");
        do begin
            @(posedge CLOCK_50);
            n++;
            @(negedge CLOCK_50);
        end while (!(wr ? write_done : read_done) && n < worst_cycles);
        assert ((wr ? write_done : read_done) == 1'b1)
        else report_problem("access did not complete in time");
        rdata = read_data;
        edges = n;
    endtask

    // fixed latency for ram and unmapped and beat count for sdram
    task automatic check_completion(input logic [63:0] a, input mem_bus_pkg::ls_type_e t,
                                    input int edges);
        int beats;
        beats = access_bytes(t) <= 2 ? 1 : access_bytes(t) / 2;
        case (region_of(a))
            mem_bus_pkg::region_sdram: begin
                assert (beat_cnt == beats)
                else report_mismatch("sdram beat count", 64'(beats), 64'(beat_cnt));
                assert (!rule_err)
                else report_problem("sdram beat broke the address or lane rule");
                assert (!sdram_cmd.read_en && !sdram_cmd.write_en)
                else report_problem("sdram command still active after done");
            end
            mem_bus_pkg::region_ram: begin
                assert (edges == (t == mem_bus_pkg::ls_d ? 3 : 2))
                else report_mismatch("ram done latency", t == mem_bus_pkg::ls_d ? 3 : 2,
                                     64'(edges));
            end
            default: begin
                assert (edges == 2) else report_mismatch("unmapped done latency", 2, 64'(edges));
            end
        endcase
    endtask

    task automatic do_store(input logic [63:0] a, input logic [63:0] d,
                            input mem_bus_pkg::ls_type_e t);
        logic [63:0] unused_data;
        int          edges;
        run_access(a, d, t, 1'b1, unused_data, edges);
        for (int i = 0; i < access_bytes(t); i++) begin
            if (region_of(a) == mem_bus_pkg::region_ram) begin
                ram_ref[12'(a + 64'(i) - `MEM_RAM_BASE)] = d[i*8 +: 8];
            end else if (region_of(a) == mem_bus_pkg::region_sdram) begin
                sdram_ref[13'(a + 64'(i))] = d[i*8 +: 8];
            end
        end
        check_completion(a, t, edges);
    endtask

    task automatic check_load(input logic [63:0] a, input mem_bus_pkg::ls_type_e t);
        logic [63:0] got;
        int          edges;
        run_access(a, 64'd0, t, 1'b0, got, edges);
        assert (got == expected_load(a, t))
        else report_mismatch("read_data", expected_load(a, t), got);
        check_completion(a, t, edges);
    endtask

    task automatic test_reset_unmapped();
        assert (read_done === 1'b1) else report_mismatch("read_done", 1, 64'(read_done));
        assert (write_done === 1'b1) else report_mismatch("write_done", 1, 64'(write_done));
        assert (read_data === '0) else report_mismatch("read_data", 0, read_data);
        assert (sdram_cmd.read_en === 1'b0)
        else report_mismatch("sdram_cmd.read_en", 0, 64'(sdram_cmd.read_en));
        assert (sdram_cmd.write_en === 1'b0)
        else report_mismatch("sdram_cmd.write_en", 0, 64'(sdram_cmd.write_en));
        check_load(64'h0000_0000_0000_0100, mem_bus_pkg::ls_w);
        do_store(64'h0000_0000_2000_0000, random_dword(), mem_bus_pkg::ls_d);
        check_load(64'h0000_0000_2000_0000, mem_bus_pkg::ls_d);
    endtask

    task automatic test_ram_word_loads();
        logic [63:0] a;
        logic [31:0] w;
        a = `MEM_RAM_BASE + 64'h40;
        // negative word and byte 0 with positive low half
        w = ($urandom | 32'h8000_0080) & ~32'h0000_8000;
        do_store(a, {$urandom, w}, mem_bus_pkg::ls_w);
        check_load(a, mem_bus_pkg::ls_w);
        check_load(a, mem_bus_pkg::ls_wu);
        for (int off = 0; off < 4; off += 2) begin
            check_load(a + 64'(off), mem_bus_pkg::ls_h);
            check_load(a + 64'(off), mem_bus_pkg::ls_hu);
        end
        for (int off = 0; off < 4; off++) begin
            check_load(a + 64'(off), mem_bus_pkg::ls_b);
            check_load(a + 64'(off), mem_bus_pkg::ls_bu);
        end
        // unmapped read must replace the nonzero data of the last load
        check_load(64'h0000_0000_0000_0100, mem_bus_pkg::ls_d);
    endtask

    task automatic test_ram_byte_lanes();
        logic [63:0] a;
        a = `MEM_RAM_BASE + 64'h80;
        do_store(a, random_dword(), mem_bus_pkg::ls_w);
        for (int off = 0; off < 4; off++) begin
            do_store(a + 64'(off), random_dword(), mem_bus_pkg::ls_b);
            check_load(a, mem_bus_pkg::ls_w);
        end
        for (int off = 0; off < 4; off += 2) begin
            do_store(a + 64'(off), random_dword(), mem_bus_pkg::ls_h);
            check_load(a, mem_bus_pkg::ls_w);
        end
    endtask

    task automatic test_ram_doubleword();
        logic [63:0] a;
        for (int i = 0; i < 2; i++) begin
            // second one only word aligned
            a = `MEM_RAM_BASE + (i == 0 ? 64'h100 : 64'h204);
            do_store(a, random_dword(), mem_bus_pkg::ls_d);
            check_load(a, mem_bus_pkg::ls_d);
            check_load(a, mem_bus_pkg::ls_w);
            check_load(a + 64'd4, mem_bus_pkg::ls_w);
        end
    endtask

    task automatic test_sdram_byte_half();
        logic [63:0] a;
        a = `MEM_SDRAM_MIN + 64'h200;
        for (int off = 0; off < 4; off++) begin
            do_store(a + 64'(off), random_dword(), mem_bus_pkg::ls_b);
        end
        do_store(a + 64'd4, random_dword(), mem_bus_pkg::ls_h);
        do_store(a + 64'd6, random_dword(), mem_bus_pkg::ls_h);
        for (int off = 0; off < 4; off++) begin
            check_load(a + 64'(off), mem_bus_pkg::ls_b);
            check_load(a + 64'(off), mem_bus_pkg::ls_bu);
        end
        for (int off = 0; off < 8; off += 2) begin
            check_load(a + 64'(off), mem_bus_pkg::ls_h);
            check_load(a + 64'(off), mem_bus_pkg::ls_hu);
        end
    endtask

    task automatic test_sdram_word_dword();
        logic [63:0] a;
        a = `MEM_SDRAM_MIN + 64'h400;
        do_store(a, random_dword() | 64'h8000_0000, mem_bus_pkg::ls_w);
        check_load(a, mem_bus_pkg::ls_w);
        check_load(a, mem_bus_pkg::ls_wu);
        // half-word aligned doubleword
        a = `MEM_SDRAM_MIN + 64'h802;
        do_store(a, random_dword(), mem_bus_pkg::ls_d);
        check_load(a, mem_bus_pkg::ls_d);
        check_load(a, mem_bus_pkg::ls_w);
        check_load(a + 64'd4, mem_bus_pkg::ls_wu);
    endtask

    initial begin
        void'($urandom(93));
        KEY0         = 1'b0;
        bus_req      = '0;
        read_enable  = 1'b0;
        write_enable = 1'b0;
        beat_clear   = 1'b0;
        exp_base     = '0;
        exp_lanes    = '0;
        repeat (reset_cycles) @(posedge CLOCK_50);
        KEY0 <= 1'b1;
        @(negedge CLOCK_50);
        test_reset_unmapped();
        test_ram_word_loads();
        test_ram_byte_lanes();
        test_ram_doubleword();
        test_sdram_byte_half();
        test_sdram_word_dword();
        if (!rule_err) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("TESTS FAILED");
            $fatal(1);
        end
    end

endmodule

// File: build.f
+incdir+hw
hw/mem_bus_pkg.sv
hw/sdram_port_pkg.sv
hw/bus_front_end.sv
hw/ram_port.sv
hw/sdram_bridge.sv
hw/mem_subsystem.sv
bench/sdram_model.sv
bench/tb_mem_subsystem.sv

// File: hw/bus_front_end.sv
`include "mem_map_consts.svh"

module bus_front_end (
    input  logic                   CLOCK_50,
    input  logic                   KEY0,
    input  mem_bus_pkg::bus_req_t  bus_req,
    input  logic                   read_enable,
    input  logic                   write_enable,
    output logic [`MEM_DATA_W-1:0] read_data,
    output logic                   read_done,
    output logic                   write_done,
    output mem_bus_pkg::bus_req_t  req,
    output logic                   ram_start,
    output logic                   sdram_start,
    input  logic                   ram_done,
    input  logic [`MEM_DATA_W-1:0] ram_rd_data,
    input  logic                   sdram_done,
    input  logic [`MEM_DATA_W-1:0] sdram_rd_data
);

    mem_bus_pkg::fe_state_e state_q;
    mem_bus_pkg::region_e   region_d;
    mem_bus_pkg::region_e   region_q;
    mem_bus_pkg::bus_req_t  req_in;
    // stand-in target for unmapped addresses
    logic                   none_start;
    logic                   none_done;
    logic                   enable;
    logic                   access_end;
    logic [`MEM_DATA_W-1:0] end_data;

    assign enable = read_enable | write_enable;

    // pulse kind decides direction
    always_comb begin
        req_in = bus_req;
        req_in.is_write = write_enable;
    end

    // decode the live request at the enable edge
    always_comb begin
        if (bus_req.addr >= `MEM_RAM_BASE &&
            bus_req.addr < `MEM_RAM_BASE + `MEM_RAM_BYTES) begin
            region_d = mem_bus_pkg::region_ram;
        end else if (bus_req.addr >= `MEM_SDRAM_MIN && bus_req.addr < `MEM_SDRAM_MAX) begin
            region_d = mem_bus_pkg::region_sdram;
        end else begin
            region_d = mem_bus_pkg::region_none;
        end
    end

    // completion of whichever target is active
    always_comb begin
        case (region_q)
            mem_bus_pkg::region_ram: begin
                access_end = ram_done;
                end_data   = ram_rd_data;
            end
            mem_bus_pkg::region_sdram: begin
                access_end = sdram_done;
                end_data   = sdram_rd_data;
            end
            default: begin
                // unmapped reads return zero
                access_end = none_done;
                end_data   = '0;
            end
        endcase
    end

    // request held for the targets until the access ends
    always_ff @(posedge CLOCK_50) begin
        if (state_q == mem_bus_pkg::fe_idle && enable) begin
            req <= req_in;
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state_q     <= mem_bus_pkg::fe_idle;
            region_q    <= mem_bus_pkg::region_none;
            ram_start   <= 1'b0;
            sdram_start <= 1'b0;
            none_start  <= 1'b0;
            none_done   <= 1'b0;
            read_done   <= 1'b1;
            write_done  <= 1'b1;
            read_data   <= '0;
        end else begin
            // starts are single-cycle
            ram_start   <= 1'b0;
            sdram_start <= 1'b0;
            none_start  <= 1'b0;
            // unmapped answers one cycle after its start
            none_done   <= none_start;
            case (state_q)
                mem_bus_pkg::fe_idle: begin
                    if (enable) begin
                        region_q    <= region_d;
                        ram_start   <= region_d == mem_bus_pkg::region_ram;
                        sdram_start <= region_d == mem_bus_pkg::region_sdram;
                        none_start  <= region_d == mem_bus_pkg::region_none;
                        // matching done drops on this edge
                        if (write_enable) begin
                            write_done <= 1'b0;
                        end else begin
                            read_done <= 1'b0;
                        end
                        state_q <= mem_bus_pkg::fe_busy;
                    end
                end
                mem_bus_pkg::fe_busy: begin
                    if (access_end) begin
                        if (req.is_write) begin
                            write_done <= 1'b1;
                        end else begin
                            // data valid together with done
                            read_data <= end_data;
                            read_done <= 1'b1;
                        end
                        state_q <= mem_bus_pkg::fe_idle;
                    end
                end
                default: state_q <= mem_bus_pkg::fe_idle;
            endcase
        end
    end

endmodule

// File: hw/mem_bus_pkg.sv
`include "mem_map_consts.svh"

package mem_bus_pkg;

    // load/store type, stores only use the low four codes
    typedef enum logic [2:0] {
        ls_b  = 3'b000,
        ls_h  = 3'b001,
        ls_w  = 3'b010,
        ls_d  = 3'b011,
        ls_bu = 3'b100,
        ls_hu = 3'b101,
        ls_wu = 3'b110
    } ls_type_e;

    // decoded target of one access
    typedef enum logic [1:0] {
        region_none,
        region_ram,
        region_sdram
    } region_e;

    // one access as handed to the targets
    typedef struct packed {
        logic [`MEM_ADDR_W-1:0] addr;
        logic [`MEM_DATA_W-1:0] wdata;
        ls_type_e               ls_type;
        logic                   is_write;
    } bus_req_t;

    typedef enum logic {
        fe_idle,
        fe_busy
    } fe_state_e;

    // raw data arrives right aligned
    function automatic logic [`MEM_DATA_W-1:0] extend_load(
        input ls_type_e               ls_type,
        input logic [`MEM_DATA_W-1:0] raw
    );
        logic [`MEM_DATA_W-1:0] ext;
        case (ls_type)
            ls_b:    ext = {{(`MEM_DATA_W-8){raw[7]}}, raw[7:0]};
            ls_h:    ext = {{(`MEM_DATA_W-16){raw[15]}}, raw[15:0]};
            ls_w:    ext = {{(`MEM_DATA_W-32){raw[31]}}, raw[31:0]};
            ls_bu:   ext = {{(`MEM_DATA_W-8){1'b0}}, raw[7:0]};
            ls_hu:   ext = {{(`MEM_DATA_W-16){1'b0}}, raw[15:0]};
            ls_wu:   ext = {{(`MEM_DATA_W-32){1'b0}}, raw[31:0]};
            // ld passes through untouched
            default: ext = raw;
        endcase
        return ext;
    endfunction

endpackage

// File: hw/mem_map_consts.svh
`ifndef MEM_MAP_CONSTS_SVH
`define MEM_MAP_CONSTS_SVH

// bus address and data width
`define MEM_ADDR_W 64
`define MEM_DATA_W 64

// on-chip ram window, byte addressed
`define MEM_RAM_BASE 64'h0000_0000_0000_1000
`define MEM_RAM_BYTES 64'd4096
// depth in 32-bit words
`define MEM_RAM_WORDS 1024

// sdram window, upper bound exclusive
`define MEM_SDRAM_MIN 64'h0000_0000_1000_0000
`define MEM_SDRAM_MAX 64'h0000_0000_1080_0000

// controller port, half-word addressed
`define MEM_SDRAM_ADDR_W 22
`define MEM_SDRAM_DATA_W 16

`endif

// File: hw/mem_subsystem.sv
`include "mem_map_consts.svh"

module mem_subsystem (
    input  logic                         CLOCK_50,
    input  logic                         KEY0,
    input  mem_bus_pkg::bus_req_t        bus_req,
    input  logic                         read_enable,
    input  logic                         write_enable,
    output logic [`MEM_DATA_W-1:0]       read_data,
    output logic                         read_done,
    output logic                         write_done,
    output sdram_port_pkg::sdram_cmd_t   sdram_cmd,
    input  logic [`MEM_SDRAM_DATA_W-1:0] sdram_rddata,
    input  logic                         sdram_req_wait
);

    // captured request, shared by both targets
    mem_bus_pkg::bus_req_t  req;
    logic                   ram_start;
    logic                   ram_done;
    logic [`MEM_DATA_W-1:0] ram_rd_data;
    logic                   sdram_start;
    logic                   sdram_done;
    logic [`MEM_DATA_W-1:0] sdram_rd_data;

    // decode and master handshake
    bus_front_end u_bus_front_end (
        .CLOCK_50      (CLOCK_50),
        .KEY0          (KEY0),
        .bus_req       (bus_req),
        .read_enable   (read_enable),
        .write_enable  (write_enable),
        .read_data     (read_data),
        .read_done     (read_done),
        .write_done    (write_done),
        .req           (req),
        .ram_start     (ram_start),
        .sdram_start   (sdram_start),
        .ram_done      (ram_done),
        .ram_rd_data   (ram_rd_data),
        .sdram_done    (sdram_done),
        .sdram_rd_data (sdram_rd_data)
    );

    ram_port u_ram_port (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .start    (ram_start),
        .req      (req),
        .rd_data  (ram_rd_data),
        .done     (ram_done)
    );

    // external controller sits outside
    sdram_bridge u_sdram_bridge (
        .CLOCK_50       (CLOCK_50),
        .KEY0           (KEY0),
        .start          (sdram_start),
        .req            (req),
        .rd_data        (sdram_rd_data),
        .done           (sdram_done),
        .sdram_cmd      (sdram_cmd),
        .sdram_rddata   (sdram_rddata),
        .sdram_req_wait (sdram_req_wait)
    );

endmodule

// File: hw/ram_port.sv
`include "mem_map_consts.svh"

module ram_port (
    input  logic                   CLOCK_50,
    input  logic                   KEY0,
    input  logic                   start,
    input  mem_bus_pkg::bus_req_t  req,
    output logic [`MEM_DATA_W-1:0] rd_data,
    output logic                   done
);

    localparam int idx_w = $clog2(`MEM_RAM_WORDS);

    // byte 0 of each word in bits 7:0
    logic [31:0]            mem [0:`MEM_RAM_WORDS-1];

    logic [`MEM_ADDR_W-1:0] offset;
    logic [idx_w-1:0]       base_idx;
    logic [idx_w-1:0]       word_idx;
    logic [1:0]             byte_off;
    // second word of ld/sd
    logic                   high_q;
    logic                   access;
    logic [3:0]             lane_we;
    logic [31:0]            wr_word;
    logic [31:0]            lo_q;
    logic [31:0]            hi_q;
    logic [`MEM_DATA_W-1:0] raw;

    // word index relative to ram base
    assign offset   = req.addr - `MEM_RAM_BASE;
    assign base_idx = offset[idx_w+1:2];
    assign byte_off = req.addr[1:0];
    // next word in the second cycle
    assign word_idx = high_q ? base_idx + 1'b1 : base_idx;
    assign access   = start | high_q;

    // lane enables and lane-replicated store data
    always_comb begin
        lane_we = 4'b0000;
        wr_word = req.wdata[31:0];
        if (access && req.is_write) begin
            if (high_q) begin
                // upper half of sd
                lane_we = 4'b1111;
                wr_word = req.wdata[63:32];
            end else begin
                case (req.ls_type)
                    mem_bus_pkg::ls_b: begin
                        lane_we = 4'b0001 << byte_off;
                        wr_word = {4{req.wdata[7:0]}};
                    end
                    mem_bus_pkg::ls_h: begin
                        lane_we = req.addr[1] ? 4'b1100 : 4'b0011;
                        wr_word = {2{req.wdata[15:0]}};
                    end
                    // sw and low half of sd
                    default: lane_we = 4'b1111;
                endcase
            end
        end
    end

    // single port array, registered read
    always_ff @(posedge CLOCK_50) begin
        for (int lane = 0; lane < 4; lane++) begin
            if (lane_we[lane]) begin
                mem[word_idx][lane*8 +: 8] <= wr_word[lane*8 +: 8];
            end
        end
        if (access && !req.is_write) begin
            if (high_q) begin
                hi_q <= mem[word_idx];
            end else begin
                lo_q <= mem[word_idx];
            end
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            high_q <= 1'b0;
            done   <= 1'b0;
        end else begin
            // doubleword takes one extra cycle
            high_q <= start && req.ls_type == mem_bus_pkg::ls_d;
            done   <= (start && req.ls_type != mem_bus_pkg::ls_d) || high_q;
        end
    end

    // ld keeps low word first, others shift down to the addressed byte
    assign raw = (req.ls_type == mem_bus_pkg::ls_d) ? {hi_q, lo_q}
                                                    : {32'b0, lo_q >> {byte_off, 3'b000}};
    assign rd_data = mem_bus_pkg::extend_load(req.ls_type, raw);

endmodule

// File: hw/sdram_bridge.sv
`include "mem_map_consts.svh"

module sdram_bridge (
    input  logic                         CLOCK_50,
    input  logic                         KEY0,
    input  logic                         start,
    input  mem_bus_pkg::bus_req_t        req,
    output logic [`MEM_DATA_W-1:0]       rd_data,
    output logic                         done,
    output sdram_port_pkg::sdram_cmd_t   sdram_cmd,
    input  logic [`MEM_SDRAM_DATA_W-1:0] sdram_rddata,
    input  logic                         sdram_req_wait
);

    sdram_port_pkg::sdram_state_e state_q;
    sdram_port_pkg::sdram_cmd_t   beat_cmd;
    // index of the beat on the port
    logic [1:0]                   beat_q;
    logic [1:0]                   last_beat;
    // beat that the next command describes
    logic [1:0]                   beat_sel;
    logic                         byte_access;
    logic                         accepted;
    logic [`MEM_SDRAM_DATA_W-1:0] beat_rd;
    logic [`MEM_DATA_W-1:0]       raw_q;

    // beats per access, minus one
    always_comb begin
        case (req.ls_type)
            mem_bus_pkg::ls_w,
            mem_bus_pkg::ls_wu: last_beat = 2'd1;
            mem_bus_pkg::ls_d:  last_beat = 2'd3;
            // byte and half fit one beat
            default:            last_beat = 2'd0;
        endcase
    end

    assign byte_access = req.ls_type == mem_bus_pkg::ls_b ||
                         req.ls_type == mem_bus_pkg::ls_bu;
    assign beat_sel = (state_q == sdram_port_pkg::sd_beat) ? beat_q + 2'd1 : 2'd0;
    // controller takes the beat when wait is low
    assign accepted = state_q == sdram_port_pkg::sd_beat && !sdram_req_wait;

    // command for beat_sel, ascending half-word addresses
    always_comb begin
        beat_cmd.addr     = req.addr[`MEM_SDRAM_ADDR_W:1] + beat_sel;
        beat_cmd.read_en  = !req.is_write;
        beat_cmd.write_en = req.is_write;
        if (byte_access) begin
            // lane from address bit 0, byte on both lanes
            beat_cmd.byte_en = req.addr[0] ? 2'b10 : 2'b01;
            beat_cmd.wrdata  = {2{req.wdata[7:0]}};
        end else begin
            beat_cmd.byte_en = 2'b11;
            beat_cmd.wrdata  = req.wdata[{beat_sel, 4'b0000} +: 16];
        end
    end

    // byte reads pick their lane and right align it
    always_comb begin
        if (!byte_access) begin
            beat_rd = sdram_rddata;
        end else if (req.addr[0]) begin
            beat_rd = {8'b0, sdram_rddata[15:8]};
        end else begin
            beat_rd = {8'b0, sdram_rddata[7:0]};
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state_q   <= sdram_port_pkg::sd_idle;
            beat_q    <= 2'd0;
            sdram_cmd <= '0;
        end else begin
            case (state_q)
                sdram_port_pkg::sd_idle: begin
                    if (start) begin
                        sdram_cmd <= beat_cmd;
                        beat_q    <= 2'd0;
                        state_q   <= sdram_port_pkg::sd_beat;
                    end
                end
                sdram_port_pkg::sd_beat: begin
                    // stall here as long as wait stays high
                    if (!sdram_req_wait) begin
                        if (beat_q == last_beat) begin
                            sdram_cmd.read_en  <= 1'b0;
                            sdram_cmd.write_en <= 1'b0;
                            state_q            <= sdram_port_pkg::sd_finish;
                        end else begin
                            // next beat goes out right away
                            sdram_cmd <= beat_cmd;
                            beat_q    <= beat_sel;
                        end
                    end
                end
                sdram_port_pkg::sd_finish: state_q <= sdram_port_pkg::sd_idle;
                default: state_q <= sdram_port_pkg::sd_idle;
            endcase
        end
    end

    // read beats fill successive 16-bit slices
    always_ff @(posedge CLOCK_50) begin
        if (accepted && !req.is_write) begin
            raw_q[{beat_q, 4'b0000} +: 16] <= beat_rd;
        end
    end

    // one-cycle done after the last beat
    assign done    = state_q == sdram_port_pkg::sd_finish;
    assign rd_data = mem_bus_pkg::extend_load(req.ls_type, raw_q);

endmodule

// File: hw/sdram_port_pkg.sv
`include "mem_map_consts.svh"

package sdram_port_pkg;

    // request side of the controller port
    // held until wait drops, one 16-bit beat per acceptance
    typedef struct packed {
        logic [`MEM_SDRAM_ADDR_W-1:0]   addr;
        logic [`MEM_SDRAM_DATA_W-1:0]   wrdata;
        // lane 0 is bits 7:0
        logic [`MEM_SDRAM_DATA_W/8-1:0] byte_en;
        logic                           read_en;
        logic                           write_en;
    } sdram_cmd_t;

    // bridge sequencer
    typedef enum logic [1:0] {
        // waiting for a start pulse
        sd_idle,
        // a command is on the port
        sd_beat,
        // last beat taken, done pulse
        sd_finish
    } sdram_state_e;

endpackage

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mem_subsystem -f build.f

out="$(./obj_dir/Vtb_mem_subsystem 2>&1 || true)"
echo "$out"

if grep -qx "TESTS PASSED" <<< "$out"; then
    exit 0
fi
exit 1
